/* hw/rv_pkg.sv */
package rv_pkg;

  localparam int CPU_WIDTH = 32;  // data and address width
  localparam int REG_ADDRW = 5;   // x0..x31
  localparam int DMEM_AW   = 8;   // word address, 256 words

  // funct3 size and sign codes, shared by loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // one memory word, seen whole, as bytes or as halves
  typedef union packed {
    logic [CPU_WIDTH-1:0]           w;
    logic [CPU_WIDTH/8-1:0][7:0]    b;   // b[0] is the lowest address
    logic [CPU_WIDTH/16-1:0][15:0]  h;
  } lsu_word_u;

endpackage

/* hw/ls_wb_if.sv */
`timescale 1ns/1ns

interface ls_wb_if;
  import rv_pkg::*;

  logic [CPU_WIDTH-1:0] exres;  // alu result, also the address for ld/st
  logic [CPU_WIDTH-1:0] lsres;  // extended load data
  logic [REG_ADDRW-1:0] rdid;
  logic                 rdwen;
  logic                 lden;   // selects lsres at writeback
  logic [CPU_WIDTH-1:0] pc;

  // producer side
  modport lsu (
    output exres, lsres, rdid, rdwen, lden, pc
  );

  // consumer side
  modport wbu (
    input  exres, lsres, rdid, rdwen, lden, pc
  );

endinterface

/* hw/lsu_ctrl.sv */
`timescale 1ns/1ns

module lsu_ctrl (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_ex_valid,
  output logic                         o_ex_ready,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_exres,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_stdata,
  input  logic [rv_pkg::REG_ADDRW-1:0] i_ex_rdid,
  input  logic                         i_ex_rdwen,
  input  logic                         i_ex_lden,
  input  logic                         i_ex_sten,
  input  logic [2:0]                   i_ex_funct3,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_pc,
  input  logic                         i_pre_ready,
  output logic                         o_pre_valid,
  output logic                         o_mem_we,
  output logic                         o_mem_re,
  output logic [rv_pkg::DMEM_AW-1:0]   o_mem_addr,
  output logic [2:0]                   o_stage_funct3,
  output logic [1:0]                   o_stage_addr_lo,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_lsres,
  ls_wb_if.lsu                         o_ls
);
  import rv_pkg::*;

  logic                 stage_valid;
  logic                 accept;
  logic [CPU_WIDTH-1:0] stage_exres;
  logic [CPU_WIDTH-1:0] stage_pc;
  logic [REG_ADDRW-1:0] stage_rdid;
  logic                 stage_rdwen;
  logic                 stage_lden;
  logic [2:0]           stage_funct3;

  // stage can take a new op when empty or when its op moves on this edge
  assign o_ex_ready = ~stage_valid | i_pre_ready;
  assign accept     = i_ex_valid & o_ex_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stage_valid <= 1'b0;
    end else if (o_ex_ready) begin
      stage_valid <= i_ex_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      stage_exres  <= i_ex_exres;
      stage_pc     <= i_ex_pc;
      stage_rdid   <= i_ex_rdid;
      stage_rdwen  <= i_ex_rdwen;
      stage_lden   <= i_ex_lden;
      stage_funct3 <= i_ex_funct3;
    end
  end

  // memory access only at acceptance, so rdata holds while the op waits
  assign o_mem_we   = accept & i_ex_sten;
  assign o_mem_re   = accept & i_ex_lden;
  assign o_mem_addr = i_ex_exres[DMEM_AW+1:2];  // word index

  assign o_stage_funct3  = stage_funct3;
  assign o_stage_addr_lo = stage_exres[1:0];
  assign o_pre_valid     = stage_valid;

  assign o_ls.exres = stage_exres;
  assign o_ls.lsres = i_lsres;  // aligned from this cycle's rdata
  assign o_ls.rdid  = stage_rdid;
  assign o_ls.rdwen = stage_rdwen;
  assign o_ls.lden  = stage_lden;
  assign o_ls.pc    = stage_pc;

endmodule

/* hw/lsu_dmem.sv */
`timescale 1ns/1ns

module lsu_dmem (
  input  logic                           i_clk,
  input  logic                           i_we,
  input  logic                           i_re,
  input  logic [rv_pkg::DMEM_AW-1:0]     i_addr,
  input  logic [rv_pkg::CPU_WIDTH/8-1:0] i_be,
  input  logic [rv_pkg::CPU_WIDTH-1:0]   i_wdata,
  output logic [rv_pkg::CPU_WIDTH-1:0]   o_rdata
);
  import rv_pkg::*;

  logic [CPU_WIDTH-1:0] mem [0:2**DMEM_AW-1];

  // byte lanes written independently
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int k = 0; k < CPU_WIDTH/8; k++) begin
        if (i_be[k]) begin
          mem[i_addr][k*8 +: 8] <= i_wdata[k*8 +: 8];
        end
      end
    end
  end

  // registered read, holds between reads
  always_ff @(posedge i_clk) begin
    if (i_re) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

/* hw/lsu_align.sv */
`timescale 1ns/1ns

module lsu_align (
  input  logic [2:0]                     i_st_funct3,
  input  logic [1:0]                     i_st_addr_lo,
  input  logic [rv_pkg::CPU_WIDTH-1:0]   i_st_data,
  output logic [rv_pkg::CPU_WIDTH/8-1:0] o_be,
  output logic [rv_pkg::CPU_WIDTH-1:0]   o_wdata,
  input  logic [2:0]                     i_ld_funct3,
  input  logic [1:0]                     i_ld_addr_lo,
  input  logic [rv_pkg::CPU_WIDTH-1:0]   i_rdata,
  output logic [rv_pkg::CPU_WIDTH-1:0]   o_lsres
);
  import rv_pkg::*;

  lsu_word_u st_word;
  lsu_word_u ld_word;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // store: copy the low bits into every lane, enables pick the lane
  always_comb begin
    st_word.w = i_st_data;
    o_be      = '1;
    case (i_st_funct3)
      F3_B: begin
        st_word.b = {(CPU_WIDTH/8){i_st_data[7:0]}};
        o_be      = 4'b0001 << i_st_addr_lo;
      end
      F3_H: begin
        st_word.h = {(CPU_WIDTH/16){i_st_data[15:0]}};
        o_be      = 4'b0011 << {i_st_addr_lo[1], 1'b0};
      end
      default: ;  // word store, all lanes
    endcase
  end

  assign o_wdata = st_word.w;

  // load: same word, read back through byte or half view
  assign ld_word.w = i_rdata;
  assign ld_byte   = ld_word.b[i_ld_addr_lo];
  assign ld_half   = ld_word.h[i_ld_addr_lo[1]];

  always_comb begin
    case (i_ld_funct3)
      F3_B:    o_lsres = {{(CPU_WIDTH-8){ld_byte[7]}}, ld_byte};
      F3_BU:   o_lsres = {{(CPU_WIDTH-8){1'b0}}, ld_byte};
      F3_H:    o_lsres = {{(CPU_WIDTH-16){ld_half[15]}}, ld_half};
      F3_HU:   o_lsres = {{(CPU_WIDTH-16){1'b0}}, ld_half};
      default: o_lsres = ld_word.w;  // F3_W
    endcase
  end

endmodule

/* hw/pipe_ls_wb.sv */
`timescale 1ns/1ns

module pipe_ls_wb (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_pre_valid,   // from load/store stage
  output logic o_pre_ready,   // to load/store stage
  output logic o_post_valid,  // to writeback
  input  logic i_post_ready,  // from writeback
  ls_wb_if.wbu i_ls,
  ls_wb_if.lsu o_wb
);
  import rv_pkg::*;

  logic                 pipewen;
  logic [CPU_WIDTH-1:0] wbu_exres;
  logic [CPU_WIDTH-1:0] wbu_lsres;
  logic [REG_ADDRW-1:0] wbu_rdid;
  logic                 wbu_rdwen;
  logic                 wbu_lden;
  logic [CPU_WIDTH-1:0] wbu_pc;

  // free when empty or being drained this cycle
  assign o_pre_ready = (o_post_valid & i_post_ready) | ~o_post_valid;
  assign pipewen     = i_pre_valid & o_pre_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_post_valid <= 1'b0;
    end else if (o_pre_ready) begin
      o_post_valid <= i_pre_valid;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wbu_exres <= '0;
      wbu_lsres <= '0;
      wbu_rdid  <= '0;
      wbu_rdwen <= 1'b0;
      wbu_lden  <= 1'b0;
      wbu_pc    <= '0;
    end else if (pipewen) begin
      wbu_exres <= i_ls.exres;
      wbu_lsres <= i_ls.lsres;
      wbu_rdid  <= i_ls.rdid;
      wbu_rdwen <= i_ls.rdwen;
      wbu_lden  <= i_ls.lden;
      wbu_pc    <= i_ls.pc;
    end
  end

  assign o_wb.exres = wbu_exres;
  assign o_wb.lsres = wbu_lsres;
  assign o_wb.rdid  = wbu_rdid;
  assign o_wb.rdwen = wbu_rdwen;
  assign o_wb.lden  = wbu_lden;
  assign o_wb.pc    = wbu_pc;

endmodule

/* hw/wb_regfile.sv */
`timescale 1ns/1ns

module wb_regfile (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_valid,
  input  logic                         i_hold,
  ls_wb_if.wbu                         i_wb,
  output logic                         o_rf_wen,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rf_waddr,
  output logic [rv_pkg::CPU_WIDTH-1:0] o_rf_wdata,
  input  logic [rv_pkg::REG_ADDRW-1:0] i_dbg_raddr,
  output logic [rv_pkg::CPU_WIDTH-1:0] o_dbg_rdata
);
  import rv_pkg::*;

  logic [CPU_WIDTH-1:0] rf [0:2**REG_ADDRW-1];

  // retire only when not held, x0 stays zero
  assign o_rf_wen   = i_valid & ~i_hold & i_wb.rdwen & (i_wb.rdid != '0);
  assign o_rf_waddr = i_wb.rdid;
  assign o_rf_wdata = i_wb.lden ? i_wb.lsres : i_wb.exres;  // wbu select

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 2**REG_ADDRW; i++) begin
        rf[i] <= '0;
      end
    end else if (o_rf_wen) begin
      rf[o_rf_waddr] <= o_rf_wdata;
    end
  end

  // debug port, no bypass of the write in flight
  assign o_dbg_rdata = (i_dbg_raddr == '0) ? '0 : rf[i_dbg_raddr];

endmodule

/* hw/lsu_wb_top.sv */
`timescale 1ns/1ns

module lsu_wb_top (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_ex_valid,
  output logic                         o_ex_ready,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_exres,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_stdata,
  input  logic [rv_pkg::REG_ADDRW-1:0] i_ex_rdid,
  input  logic                         i_ex_rdwen,
  input  logic                         i_ex_lden,
  input  logic                         i_ex_sten,
  input  logic [2:0]                   i_ex_funct3,
  input  logic [rv_pkg::CPU_WIDTH-1:0] i_ex_pc,
  input  logic                         i_wb_hold,
  output logic                         o_commit_valid,
  output logic [rv_pkg::CPU_WIDTH-1:0] o_commit_pc,
  output logic                         o_rf_wen,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rf_waddr,
  output logic [rv_pkg::CPU_WIDTH-1:0] o_rf_wdata,
  input  logic [rv_pkg::REG_ADDRW-1:0] i_dbg_raddr,
  output logic [rv_pkg::CPU_WIDTH-1:0] o_dbg_rdata
);
  import rv_pkg::*;

  logic                   pre_valid;
  logic                   pre_ready;
  logic                   post_valid;
  logic                   mem_we;
  logic                   mem_re;
  logic [DMEM_AW-1:0]     mem_addr;
  logic [CPU_WIDTH/8-1:0] mem_be;
  logic [CPU_WIDTH-1:0]   mem_wdata;
  logic [CPU_WIDTH-1:0]   mem_rdata;
  logic [2:0]             stage_funct3;
  logic [1:0]             stage_addr_lo;
  logic [CPU_WIDTH-1:0]   lsres;

  ls_wb_if ls_pre ();   // load/store stage to pipe register
  ls_wb_if ls_post ();  // pipe register to writeback

  lsu_ctrl u_lsu_ctrl (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_ex_valid(i_ex_valid), .o_ex_ready(o_ex_ready),
    .i_ex_exres(i_ex_exres), .i_ex_stdata(i_ex_stdata),
    .i_ex_rdid(i_ex_rdid), .i_ex_rdwen(i_ex_rdwen),
    .i_ex_lden(i_ex_lden), .i_ex_sten(i_ex_sten),
    .i_ex_funct3(i_ex_funct3), .i_ex_pc(i_ex_pc),
    .i_pre_ready(pre_ready), .o_pre_valid(pre_valid),
    .o_mem_we(mem_we), .o_mem_re(mem_re), .o_mem_addr(mem_addr),
    .o_stage_funct3(stage_funct3), .o_stage_addr_lo(stage_addr_lo),
    .i_lsres(lsres), .o_ls(ls_pre.lsu)
  );

  // store lanes come straight from the execute inputs
  lsu_align u_lsu_align (
    .i_st_funct3(i_ex_funct3), .i_st_addr_lo(i_ex_exres[1:0]),
    .i_st_data(i_ex_stdata), .o_be(mem_be), .o_wdata(mem_wdata),
    .i_ld_funct3(stage_funct3), .i_ld_addr_lo(stage_addr_lo),
    .i_rdata(mem_rdata), .o_lsres(lsres)
  );

  lsu_dmem u_lsu_dmem (
    .i_clk(i_clk), .i_we(mem_we), .i_re(mem_re), .i_addr(mem_addr),
    .i_be(mem_be), .i_wdata(mem_wdata), .o_rdata(mem_rdata)
  );

  pipe_ls_wb u_pipe_ls_wb (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_pre_valid(pre_valid), .o_pre_ready(pre_ready),
    .o_post_valid(post_valid), .i_post_ready(~i_wb_hold),
    .i_ls(ls_pre.wbu), .o_wb(ls_post.lsu)
  );

  wb_regfile u_wb_regfile (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_valid(post_valid), .i_hold(i_wb_hold), .i_wb(ls_post.wbu),
    .o_rf_wen(o_rf_wen), .o_rf_waddr(o_rf_waddr), .o_rf_wdata(o_rf_wdata),
    .i_dbg_raddr(i_dbg_raddr), .o_dbg_rdata(o_dbg_rdata)
  );

  assign o_commit_valid = post_valid & ~i_wb_hold;  // retires this edge
  assign o_commit_pc    = ls_post.pc;

endmodule

/* verif/lsu_wb_assertions.sv */
`timescale 1ns/1ns

module lsu_wb_assertions (
  input logic                         i_clk,
  input logic                         i_arst_n,
  input logic                         i_wb_hold,
  input logic                         i_post_valid,
  input logic                         i_commit_valid,
  input logic [rv_pkg::CPU_WIDTH-1:0] i_commit_pc,
  input logic                         i_rf_wen,
  input logic [rv_pkg::REG_ADDRW-1:0] i_rf_waddr,
  input logic [rv_pkg::CPU_WIDTH-1:0] i_rf_wdata
);

  int fail_count = 0;

  // nothing retires while reset is applied
  a_reset_quiet: assert property (@(posedge i_clk) !i_arst_n |-> !i_commit_valid && !i_rf_wen)
    else begin
      $error("commit or register write during reset");
      fail_count++;
    end

  a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                                  i_rf_wen |-> i_rf_waddr != '0)
    else begin
      $error("register write to x0");
      fail_count++;
    end

  // a held op keeps its outputs until it retires
  a_hold_frozen: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                                  i_wb_hold && i_post_valid |=>
                                  $stable(i_commit_pc) && $stable(i_rf_waddr) &&
                                  $stable(i_rf_wdata))
    else begin
      $error("writeback outputs changed under hold");
      fail_count++;
    end

endmodule

bind lsu_wb_top lsu_wb_assertions u_lsu_wb_assertions (
  .i_clk(i_clk), .i_arst_n(i_arst_n), .i_wb_hold(i_wb_hold),
  .i_post_valid(post_valid), .i_commit_valid(o_commit_valid),
  .i_commit_pc(o_commit_pc), .i_rf_wen(o_rf_wen),
  .i_rf_waddr(o_rf_waddr), .i_rf_wdata(o_rf_wdata)
);

/* verif/tb_lsu_wb.sv */
`timescale 1ns/1ns

module tb_lsu_wb;
  import rv_pkg::*;

  typedef struct packed {
    logic [CPU_WIDTH-1:0] pc;
    logic                 wen;
    logic [REG_ADDRW-1:0] waddr;
    logic [CPU_WIDTH-1:0] wdata;
    int                   cyc;   // monitor cycle at acceptance
  } commit_t;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 ex_valid;
  logic                 ex_ready;
  logic [CPU_WIDTH-1:0] ex_exres;
  logic [CPU_WIDTH-1:0] ex_stdata;
  logic [REG_ADDRW-1:0] ex_rdid;
  logic                 ex_rdwen;
  logic                 ex_lden;
  logic                 ex_sten;
  logic [2:0]           ex_funct3;
  logic [CPU_WIDTH-1:0] ex_pc;
  logic                 wb_hold;
  logic                 commit_valid;
  logic [CPU_WIDTH-1:0] commit_pc;
  logic                 rf_wen;
  logic [REG_ADDRW-1:0] rf_waddr;
  logic [CPU_WIDTH-1:0] rf_wdata;
  logic [REG_ADDRW-1:0] dbg_raddr;
  logic [CPU_WIDTH-1:0] dbg_rdata;

  commit_t              exp_q[$];   // accepted but not yet retired
  logic [7:0]           mem_model [0:1023];
  logic [CPU_WIDTH-1:0] reg_model [0:31];
  integer               seed = 59601;
  int                   cyc = 0;
  int                   errors = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;
  int                   err_at_start;
  logic                 hold_en = 1'b0;
  logic [CPU_WIDTH-1:0] next_pc = 32'h8000_0000;
  logic [REG_ADDRW-1:0] next_rd = 5'd1;
  string                test_name = "none";

  lsu_wb_top dut (
    .i_clk(clk), .i_arst_n(arst_n), .i_ex_valid(ex_valid), .o_ex_ready(ex_ready),
    .i_ex_exres(ex_exres), .i_ex_stdata(ex_stdata), .i_ex_rdid(ex_rdid),
    .i_ex_rdwen(ex_rdwen), .i_ex_lden(ex_lden), .i_ex_sten(ex_sten),
    .i_ex_funct3(ex_funct3), .i_ex_pc(ex_pc), .i_wb_hold(wb_hold),
    .o_commit_valid(commit_valid), .o_commit_pc(commit_pc), .o_rf_wen(rf_wen),
    .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
    .i_dbg_raddr(dbg_raddr), .o_dbg_rdata(dbg_rdata)
  );

  always #20 clk = ~clk;  // 40 ns period

  // back-pressure drawn at the edge and applied with the other inputs
  always @(posedge clk) begin
    logic coin;
    coin = hold_en & 1'($random(seed));
    #2;
    wb_hold = coin;
  end

  function automatic int total_errors();
    return errors + dut.u_lsu_wb_assertions.fail_count;
  endfunction

  task automatic compare_value(input string what, input logic [CPU_WIDTH-1:0] expected,
                               input logic [CPU_WIDTH-1:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("Finished with errors");
    $finish;
  endtask

  // a commit seen mid-cycle retires on the next edge
  always @(negedge clk) begin
    commit_t head;
    if (arst_n) begin
      assert (ex_ready || (exp_q.size() == 2 && wb_hold)) else begin
        $display("%s: ready dropped with %0d ops in flight and hold %0b", test_name,
                 exp_q.size(), wb_hold);
        errors++;
      end
      assert (!rf_wen || commit_valid) else begin
        $display("%s: register write without a commit", test_name);
        errors++;
      end
      if (commit_valid && exp_q.size() == 0) begin
        $display("%s: commit with no op in flight", test_name);
        errors++;
      end else if (commit_valid) begin
        head = exp_q.pop_front();
        compare_value("commit pc", head.pc, commit_pc);
        compare_value("rf wen", 32'(head.wen), 32'(rf_wen));
        if (head.wen) begin
          compare_value("rf waddr", 32'(head.waddr), 32'(rf_waddr));
          compare_value("rf wdata", head.wdata, rf_wdata);
        end
        if (!hold_en) compare_value("commit cycle", 32'(head.cyc + 1), 32'(cyc));
      end
    end
    cyc++;
  end

  task automatic apply_store(input logic [CPU_WIDTH-1:0] addr, input logic [2:0] f3,
                             input logic [CPU_WIDTH-1:0] data);
    case (f3)
      F3_B: mem_model[addr[9:0]] = data[7:0];
      F3_H: begin
        mem_model[{addr[9:1], 1'b0}] = data[7:0];
        mem_model[{addr[9:1], 1'b1}] = data[15:8];
      end
      default: begin
        mem_model[{addr[9:2], 2'd0}] = data[7:0];
        mem_model[{addr[9:2], 2'd1}] = data[15:8];
        mem_model[{addr[9:2], 2'd2}] = data[23:16];
        mem_model[{addr[9:2], 2'd3}] = data[31:24];
      end
    endcase
  endtask

  function automatic logic [CPU_WIDTH-1:0] expected_load(input logic [CPU_WIDTH-1:0] addr,
                                                         input logic [2:0] f3);
    logic [7:0]  b;
    logic [15:0] h;
    b = mem_model[addr[9:0]];
    h = {mem_model[{addr[9:1], 1'b1}], mem_model[{addr[9:1], 1'b0}]};
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_BU:   return {24'b0, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_HU:   return {16'b0, h};
      default: return {mem_model[{addr[9:2], 2'd3}], mem_model[{addr[9:2], 2'd2}],
                       mem_model[{addr[9:2], 2'd1}], mem_model[{addr[9:2], 2'd0}]};
    endcase
  endfunction

  // called 2 ns after an edge and returns 2 ns after the acceptance edge
  task automatic issue_op(input logic [CPU_WIDTH-1:0] exres, input logic [CPU_WIDTH-1:0] stdata,
                          input logic [REG_ADDRW-1:0] rdid, input logic rdwen,
                          input logic lden, input logic sten, input logic [2:0] f3);
    commit_t exp;
    int      tries;
    tries     = 0;
    ex_valid  = 1'b1;
    ex_exres  = exres;
    ex_stdata = stdata;
    ex_rdid   = rdid;
    ex_rdwen  = rdwen;
    ex_lden   = lden;
    ex_sten   = sten;
    ex_funct3 = f3;
    ex_pc     = next_pc;
    @(negedge clk);
    while (!ex_ready) begin
      tries++;
      if (tries > 20) abort_run("op never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    ex_valid = 1'b0;  // raised again at once if another op follows
    if (sten) apply_store(exres, f3, stdata);
    exp.pc    = next_pc;
    exp.wen   = rdwen && (rdid != '0);
    exp.waddr = rdid;
    exp.wdata = lden ? expected_load(exres, f3) : exres;
    exp.cyc   = cyc;
    if (exp.wen) reg_model[rdid] = exp.wdata;
    exp_q.push_back(exp);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic alu_op(input logic [REG_ADDRW-1:0] rd, input logic [CPU_WIDTH-1:0] value);
    issue_op(value, '0, rd, 1'b1, 1'b0, 1'b0, F3_W);
  endtask

  task automatic store_op(input logic [CPU_WIDTH-1:0] addr, input logic [2:0] f3,
                          input logic [CPU_WIDTH-1:0] data);
    issue_op(addr, data, '0, 1'b0, 1'b0, 1'b1, f3);
  endtask

  task automatic load_op(input logic [CPU_WIDTH-1:0] addr, input logic [2:0] f3);
    issue_op(addr, '0, next_rd, 1'b1, 1'b1, 1'b0, f3);
    next_rd = (next_rd == 5'd31) ? 5'd1 : next_rd + 5'd1;  // x1..x31 in turn
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 100) abort_run("pipeline did not drain");
    end
  endtask

  task automatic check_regfile();
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      #2;
      dbg_raddr = 5'(r);
      @(negedge clk);
      compare_value($sformatf("debug read x%0d", r), reg_model[r], dbg_rdata);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() == err_at_start) begin
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL", test_name);
    end
  endtask

  function automatic logic [2:0] store_code(input int unsigned n);
    case (n)
      0:       return F3_B;
      1:       return F3_H;
      default: return F3_W;
    endcase
  endfunction

  function automatic logic [2:0] load_code(input int unsigned n);
    case (n)
      0:       return F3_B;
      1:       return F3_BU;
      2:       return F3_H;
      3:       return F3_HU;
      default: return F3_W;
    endcase
  endfunction

  function automatic logic [1:0] align_offset(input logic [2:0] f3, input logic [1:0] off);
    case (f3)
      F3_B, F3_BU: return off;
      F3_H, F3_HU: return {off[1], 1'b0};
      default:     return 2'b00;
    endcase
  endfunction

  initial begin
    logic [CPU_WIDTH-1:0] base;
    logic [CPU_WIDTH-1:0] addr;
    logic [2:0]           f3;
    int unsigned          kind;
    arst_n    = 1'b0;
    ex_valid  = 1'b0;
    ex_exres  = '0;
    ex_stdata = '0;
    ex_rdid   = '0;
    ex_rdwen  = 1'b0;
    ex_lden   = 1'b0;
    ex_sten   = 1'b0;
    ex_funct3 = F3_W;
    ex_pc     = '0;
    wb_hold   = 1'b0;
    dbg_raddr = '0;
    for (int r = 0; r < 32; r++) reg_model[r] = '0;
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;

    start_test("reset_state");
    @(negedge clk);
    compare_value("ex ready", 32'd1, 32'(ex_ready));
    compare_value("commit valid", 32'd0, 32'(commit_valid));
    compare_value("rf wen", 32'd0, 32'(rf_wen));
    @(posedge clk);
    #2;
    check_regfile();
    end_test();

    start_test("alu_writeback");
    for (int i = 0; i < 24; i++) alu_op(5'($random(seed)), $random(seed));
    issue_op(32'h1234_5678, '0, 5'd7, 1'b0, 1'b0, 1'b0, F3_W);  // no write enable
    alu_op(5'd0, 32'hffff_ffff);  // x0 stays zero
    drain_pipeline();
    check_regfile();
    end_test();

    start_test("store_load_word");
    for (int i = 0; i < 8; i++) begin
      addr = 32'(i * 4);
      store_op(addr, F3_W, $random(seed));
      load_op(addr, F3_W);  // issued on the very next edge
    end
    drain_pipeline();
    check_regfile();
    end_test();

    start_test("subword_ext");
    for (int w = 16; w < 20; w++) begin
      base = 32'(w * 4);
      for (int off = 0; off < 4; off++) store_op(base + 32'(off), F3_B, $random(seed));
      for (int off = 0; off < 4; off++) begin
        load_op(base + 32'(off), F3_B);
        load_op(base + 32'(off), F3_BU);
      end
      load_op(base, F3_W);
      for (int off = 0; off < 4; off += 2) store_op(base + 32'(off), F3_H, $random(seed));
      for (int off = 0; off < 4; off += 2) begin
        load_op(base + 32'(off), F3_H);
        load_op(base + 32'(off), F3_HU);
      end
      load_op(base, F3_W);
    end
    drain_pipeline();
    check_regfile();
    end_test();

    start_test("random_hold");
    for (int i = 32; i < 48; i++) store_op(32'(i * 4), F3_W, $random(seed));
    hold_en = 1'b1;
    for (int i = 0; i < 60; i++) begin
      kind = $unsigned($random(seed)) % 3;
      addr = 32'd128 + {26'b0, 4'($random(seed)), 2'b00};  // words 32..47
      if (kind == 0) begin
        alu_op(5'($random(seed)), $random(seed));
      end else if (kind == 1) begin
        f3        = store_code($unsigned($random(seed)) % 3);
        addr[1:0] = align_offset(f3, 2'($random(seed)));
        store_op(addr, f3, $random(seed));
      end else begin
        f3        = load_code($unsigned($random(seed)) % 5);
        addr[1:0] = align_offset(f3, 2'($random(seed)));
        load_op(addr, f3);
      end
    end
    drain_pipeline();
    hold_en = 1'b0;
    check_regfile();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* filelist.f */
hw/rv_pkg.sv
hw/ls_wb_if.sv
hw/lsu_ctrl.sv
hw/lsu_dmem.sv
hw/lsu_align.sv
hw/pipe_ls_wb.sv
hw/wb_regfile.sv
hw/lsu_wb_top.sv
verif/lsu_wb_assertions.sv
verif/tb_lsu_wb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_lsu_wb -f filelist.f &&
./obj_dir/Vtb_lsu_wb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
